// File: common/csr_pkg.sv
// csr package: widths, CSR addresses and the shared types of the CSR unit
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////////////////////////
  // sizes and fixed fields
  ////////////////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned N_PERF_CNT = 12;

  // vectored mode, low bits of mtvec
  localparam logic [1:0] MTVEC_MODE = 2'b01;

  // mstatus bit positions
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LSB  = 11;

  // PCMR fields
  localparam int unsigned PCMR_EN_BIT  = 0;
  localparam int unsigned PCMR_SAT_BIT = 1;
  localparam logic [1:0]  PCMR_RESET   = 2'b11;

  ////////////////////////////////////////////////////////////
  // CSR addresses
  ////////////////////////////////////////////////////////////

  localparam logic [11:0] CSR_MSTATUS  = 12'h300;
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;
  localparam logic [11:0] CSR_MHARTID  = 12'hF14;
  localparam logic [11:0] CSR_PCER     = 12'h7A0;
  localparam logic [11:0] CSR_PCMR     = 12'h7A1;
  localparam logic [11:0] CSR_PCCR_ALL = 12'h79F;

  // counter window 780..79F
  localparam logic [6:0] PCCR_GROUP = 7'b0111100;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // only M is ever produced
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // counter window view of an address
  typedef struct packed {
    logic [6:0] grp;
    logic [4:0] idx;
  } csr_cnt_addr_t;

  typedef union packed {
    logic [11:0]   raw;
    csr_cnt_addr_t cnt;
  } csr_addr_u;

  typedef struct packed {
    logic            access;
    csr_addr_u       addr;
    csr_op_e         op;
    logic [XLEN-1:0] wdata;
  } csr_req_t;

  // write after the operation has been resolved
  typedef struct packed {
    logic            we;
    csr_addr_u       addr;
    logic [XLEN-1:0] wdata;
  } csr_wr_t;

  typedef struct packed {
    logic       save_cause;
    logic       save_if;
    logic       save_id;
    logic       restore_mret;
    logic [5:0] cause;
  } trap_ctrl_t;

  typedef struct packed {
    logic      mie;
    logic      mpie;
    priv_lvl_e mpp;
  } mstatus_t;

  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic pipeline_stall;
    logic mem_load;
    logic mem_store;
  } perf_evt_t;

  typedef logic [N_PERF_CNT-1:0] perf_cnt_vec_t;

endpackage

`default_nettype wire

// File: perf/perf_events.sv
// performance events: per-cycle event vector built from pipeline status
`timescale 1ns/100ps
`default_nettype none

module perf_events (
  input  logic                   clk,
  input  logic                   rst_n,
  input  csr_pkg::perf_evt_t     perf_evt_i,
  output csr_pkg::perf_cnt_vec_t events_o
);

  // ID stage finished an instruction last cycle
  logic id_valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
    end else begin
      id_valid_q <= perf_evt_i.id_valid;
    end
  end

  // stall, jump and branch events gated so each instruction counts once
  always_comb begin
    events_o[0]  = 1'b1;
    events_o[1]  = perf_evt_i.id_valid & perf_evt_i.is_decoding;
    events_o[2]  = perf_evt_i.ld_stall & id_valid_q;
    events_o[3]  = perf_evt_i.jr_stall & id_valid_q;
    // fetch wait, not counting redirects
    events_o[4]  = perf_evt_i.imiss & ~perf_evt_i.pc_set;
    events_o[5]  = perf_evt_i.mem_load;
    events_o[6]  = perf_evt_i.mem_store;
    events_o[7]  = perf_evt_i.jump & id_valid_q;
    events_o[8]  = perf_evt_i.branch & id_valid_q;
    events_o[9]  = perf_evt_i.branch & perf_evt_i.branch_taken & id_valid_q;
    events_o[10] = perf_evt_i.id_valid & perf_evt_i.is_decoding & perf_evt_i.is_compressed;
    events_o[11] = perf_evt_i.pipeline_stall;
  end

endmodule

`default_nettype wire

// File: perf/perf_counter_bank.sv
// performance counter bank: counters, PCER, PCMR and their CSR access
`timescale 1ns/100ps
`default_nettype none

module perf_counter_bank (
  input  logic                     clk,
  input  logic                     rst_n,

  input  csr_pkg::csr_wr_t         wr_i,
  input  csr_pkg::csr_addr_u       raddr_i,

  input  csr_pkg::perf_cnt_vec_t   events_i,

  output logic [csr_pkg::XLEN-1:0] rdata_o,
  output logic                     hit_o
);

  logic [csr_pkg::N_PERF_CNT-1:0][csr_pkg::XLEN-1:0] cnt_q;
  logic [csr_pkg::N_PERF_CNT-1:0][csr_pkg::XLEN-1:0] cnt_n;

  csr_pkg::perf_cnt_vec_t pcer_q;
  csr_pkg::perf_cnt_vec_t inc;
  csr_pkg::perf_cnt_vec_t inc_q;
  logic [1:0]             pcmr_q;

  logic wr_pcer;
  logic wr_pcmr;
  logic wr_cnt;
  logic wr_all;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  assign wr_pcer = wr_i.we && (wr_i.addr.raw == csr_pkg::CSR_PCER);
  assign wr_pcmr = wr_i.we && (wr_i.addr.raw == csr_pkg::CSR_PCMR);
  assign wr_cnt  = wr_i.we && (wr_i.addr.cnt.grp == csr_pkg::PCCR_GROUP);
  assign wr_all  = (wr_i.addr.raw == csr_pkg::CSR_PCCR_ALL);

  // whole window hits, only indices below 12 return data
  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b0;
    if (raddr_i.raw == csr_pkg::CSR_PCER) begin
      hit_o = 1'b1;
      rdata_o[csr_pkg::N_PERF_CNT-1:0] = pcer_q;
    end else if (raddr_i.raw == csr_pkg::CSR_PCMR) begin
      hit_o        = 1'b1;
      rdata_o[1:0] = pcmr_q;
    end else if (raddr_i.cnt.grp == csr_pkg::PCCR_GROUP) begin
      hit_o = 1'b1;
      for (int i = 0; i < csr_pkg::N_PERF_CNT; i++) begin
        if (raddr_i.cnt.idx == 5'(i)) begin
          rdata_o = cnt_q[i];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // counter update
  ////////////////////////////////////////////////////////////

  // one-cycle increment pipeline
  assign inc = events_i & pcer_q & {csr_pkg::N_PERF_CNT{pcmr_q[csr_pkg::PCMR_EN_BIT]}};

  always_comb begin
    for (int i = 0; i < csr_pkg::N_PERF_CNT; i++) begin
      cnt_n[i] = cnt_q[i];
      // saturating mode holds at all ones
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[csr_pkg::PCMR_SAT_BIT])) begin
        cnt_n[i] = cnt_q[i] + 1'b1;
      end
      // CSR write beats the increment
      if (wr_cnt && (wr_all || (wr_i.addr.cnt.idx == 5'(i)))) begin
        cnt_n[i] = wr_i.wdata;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      inc_q  <= '0;
      pcer_q <= '0;
      pcmr_q <= csr_pkg::PCMR_RESET;
    end else begin
      cnt_q <= cnt_n;
      inc_q <= inc;
      if (wr_pcer) begin
        pcer_q <= wr_i.wdata[csr_pkg::N_PERF_CNT-1:0];
      end
      if (wr_pcmr) begin
        pcmr_q <= wr_i.wdata[1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: trap/trap_csr.sv
// machine trap registers with trap entry and MRET sequencing
`timescale 1ns/100ps
`default_nettype none

module trap_csr (
  input  logic                     clk,
  input  logic                     rst_n,

  input  csr_pkg::csr_wr_t         wr_i,
  input  csr_pkg::csr_addr_u       raddr_i,

  input  csr_pkg::trap_ctrl_t      trap_i,
  input  logic [csr_pkg::XLEN-1:0] pc_if_i,
  input  logic [csr_pkg::XLEN-1:0] pc_id_i,
  input  logic [3:0]               core_id_i,
  input  logic [5:0]               cluster_id_i,

  output logic [csr_pkg::XLEN-1:0] rdata_o,
  output logic                     hit_o,

  output logic [csr_pkg::XLEN-1:0] mepc_o,
  output logic [23:0]              mtvec_o,
  output logic                     m_irq_enable_o
);

  csr_pkg::mstatus_t        mstatus_q;
  csr_pkg::mstatus_t        mstatus_n;
  logic [23:0]              mtvec_q;
  logic [23:0]              mtvec_n;
  logic [csr_pkg::XLEN-1:0] mepc_q;
  logic [csr_pkg::XLEN-1:0] mepc_n;
  logic [5:0]               mcause_q;
  logic [5:0]               mcause_n;
  logic [csr_pkg::XLEN-1:0] exception_pc;

  ////////////////////////////////////////////////////////////
  // read decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (raddr_i.raw)
      csr_pkg::CSR_MSTATUS: begin
        rdata_o[csr_pkg::MSTATUS_MIE_BIT]  = mstatus_q.mie;
        rdata_o[csr_pkg::MSTATUS_MPIE_BIT] = mstatus_q.mpie;
        rdata_o[csr_pkg::MSTATUS_MPP_LSB +: 2] = mstatus_q.mpp;
      end
      csr_pkg::CSR_MTVEC:   rdata_o = {mtvec_q, 6'h0, csr_pkg::MTVEC_MODE};
      csr_pkg::CSR_MEPC:    rdata_o = mepc_q;
      csr_pkg::CSR_MCAUSE:  rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      // hart id from cluster and core
      csr_pkg::CSR_MHARTID: rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default:              hit_o   = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_n = mstatus_q;
    mtvec_n   = mtvec_q;
    mepc_n    = mepc_q;
    mcause_n  = mcause_q;

    // pc_id is the default source, save_id just selects it
    exception_pc = trap_i.save_if ? pc_if_i : pc_id_i;

    if (wr_i.we) begin
      case (wr_i.addr.raw)
        csr_pkg::CSR_MSTATUS: begin
          mstatus_n.mie  = wr_i.wdata[csr_pkg::MSTATUS_MIE_BIT];
          mstatus_n.mpie = wr_i.wdata[csr_pkg::MSTATUS_MPIE_BIT];
        end
        csr_pkg::CSR_MTVEC:  mtvec_n  = wr_i.wdata[31:8];
        csr_pkg::CSR_MEPC:   mepc_n   = wr_i.wdata;
        csr_pkg::CSR_MCAUSE: mcause_n = {wr_i.wdata[31], wr_i.wdata[4:0]};
        default: ;
      endcase
    end

    // trap entry and MRET override the fields they touch
    if (trap_i.save_cause) begin
      mepc_n         = exception_pc;
      mcause_n       = trap_i.cause;
      mstatus_n.mpie = mstatus_q.mie;
      mstatus_n.mie  = 1'b0;
    end else if (trap_i.restore_mret) begin
      mstatus_n.mie  = mstatus_q.mpie;
      mstatus_n.mpie = 1'b1;
    end

    // machine mode only
    mstatus_n.mpp = csr_pkg::PRIV_LVL_M;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '{mie: 1'b0, mpie: 1'b0, mpp: csr_pkg::PRIV_LVL_M};
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_n;
      mtvec_q   <= mtvec_n;
      mepc_q    <= mepc_n;
      mcause_q  <= mcause_n;
    end
  end

  assign mepc_o         = mepc_q;
  assign mtvec_o        = mtvec_q;
  assign m_irq_enable_o = mstatus_q.mie;

endmodule

`default_nettype wire

// File: logic/csr_unit.sv
// csr unit top: resolves the CSR operation and merges read data of trap and counter banks
`timescale 1ns/100ps
`default_nettype none

module csr_unit (
  input  logic                         clk,
  input  logic                         rst_n,

  // single-cycle CSR port
  input  csr_pkg::csr_req_t            csr_req_i,
  output logic [csr_pkg::XLEN-1:0]     csr_rdata_o,

  // trap control from the controller
  input  csr_pkg::trap_ctrl_t          trap_i,
  input  logic [csr_pkg::XLEN-1:0]     pc_if_i,
  input  logic [csr_pkg::XLEN-1:0]     pc_id_i,

  input  logic [3:0]                   core_id_i,
  input  logic [5:0]                   cluster_id_i,

  input  csr_pkg::perf_evt_t           perf_evt_i,

  output logic [csr_pkg::XLEN-1:0]     mepc_o,
  output logic [23:0]                  mtvec_o,
  output logic                         m_irq_enable_o
);

  csr_pkg::csr_wr_t         wr;
  csr_pkg::perf_cnt_vec_t   events;

  logic [csr_pkg::XLEN-1:0] trap_rdata;
  logic [csr_pkg::XLEN-1:0] perf_rdata;
  logic                     trap_hit;
  logic                     perf_hit;

  ////////////////////////////////////////////////////////////
  // read data select
  ////////////////////////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    // nothing is returned without an access
    if (csr_req_i.access) begin
      if (perf_hit) begin
        csr_rdata_o = perf_rdata;
      end else if (trap_hit) begin
        csr_rdata_o = trap_rdata;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // operation resolve
  ////////////////////////////////////////////////////////////

  // set and clear act on the current read word
  always_comb begin
    wr.we   = csr_req_i.access && (csr_req_i.op != csr_pkg::CSR_OP_NONE);
    wr.addr = csr_req_i.addr;
    case (csr_req_i.op)
      csr_pkg::CSR_OP_SET:   wr.wdata = csr_req_i.wdata | csr_rdata_o;
      csr_pkg::CSR_OP_CLEAR: wr.wdata = csr_rdata_o & ~csr_req_i.wdata;
      default:               wr.wdata = csr_req_i.wdata;
    endcase
  end

  trap_csr trap_csr_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_i           (wr),
    .raddr_i        (csr_req_i.addr),
    .trap_i         (trap_i),
    .pc_if_i        (pc_if_i),
    .pc_id_i        (pc_id_i),
    .core_id_i      (core_id_i),
    .cluster_id_i   (cluster_id_i),
    .rdata_o        (trap_rdata),
    .hit_o          (trap_hit),
    .mepc_o         (mepc_o),
    .mtvec_o        (mtvec_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  perf_events perf_events_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .perf_evt_i (perf_evt_i),
    .events_o   (events)
  );

  perf_counter_bank perf_counter_bank_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_i     (wr),
    .raddr_i  (csr_req_i.addr),
    .events_i (events),
    .rdata_o  (perf_rdata),
    .hit_o    (perf_hit)
  );

endmodule

`default_nettype wire

// File: verif/csr_unit_properties.sv
// CSR unit properties: MPP read-back, idle read data and trap entry MIE clear
`timescale 1ns/100ps
`default_nettype none

module csr_unit_properties (
  input logic                     clk,
  input logic                     rst_n,
  input csr_pkg::csr_req_t        req_i,
  input logic [csr_pkg::XLEN-1:0] rdata_i,
  input csr_pkg::trap_ctrl_t      trap_i,
  input logic                     mie_i
);

  // machine mode only
  mpp_reads_machine: assert property (@(posedge clk) disable iff (!rst_n)
    (req_i.access && req_i.addr.raw == csr_pkg::CSR_MSTATUS)
      |-> (rdata_i[csr_pkg::MSTATUS_MPP_LSB +: 2] == csr_pkg::PRIV_LVL_M))
    else $error("mstatus MPP read back other than machine mode");

  idle_rdata_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !req_i.access |-> (rdata_i == '0))
    else $error("read data not zero without an access");

  trap_clears_mie: assert property (@(posedge clk) disable iff (!rst_n)
    trap_i.save_cause |=> !mie_i)
    else $error("MIE still set after trap entry");

endmodule

bind csr_unit csr_unit_properties csr_unit_properties_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .req_i   (csr_req_i),
  .rdata_i (csr_rdata_o),
  .trap_i  (trap_i),
  .mie_i   (m_irq_enable_o)
);

`default_nettype wire

// File: verif/csr_unit_tb.sv
// testbench for the CSR unit: directed and random CSR, trap and counter traffic checked per cycle
`timescale 1ns/100ps
`default_nettype none

module csr_unit_tb;

  logic                clk = 1'b0;
  logic                rst_n;
  csr_pkg::csr_req_t   csr_req;
  logic [31:0]         csr_rdata;
  csr_pkg::trap_ctrl_t trap;
  logic [31:0]         pc_if;
  logic [31:0]         pc_id;
  logic [3:0]          core_id;
  logic [5:0]          cluster_id;
  csr_pkg::perf_evt_t  perf_evt;
  logic [31:0]         mepc;
  logic [23:0]         mtvec;
  logic                m_irq_enable;

  // reference state, stepped at each falling edge for the coming rising edge
  csr_pkg::mstatus_t m_mstatus;
  logic [23:0]       m_mtvec;
  logic [31:0]       m_mepc;
  logic [5:0]        m_mcause;
  logic [11:0]       m_pcer;
  logic [1:0]        m_pcmr;
  logic [11:0]       m_inc;
  logic              m_idv;
  logic [31:0]       m_cnt [12];

  logic [31:0] rng_state = 32'hd401;
  int unsigned n_checks  = 0;
  logic [11:0] addr_list [8] = '{csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MTVEC, csr_pkg::CSR_MEPC,
                                 csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MHARTID, csr_pkg::CSR_PCER,
                                 csr_pkg::CSR_PCMR, csr_pkg::CSR_PCCR_ALL};

  always #2 clk = ~clk;

  csr_unit csr_unit_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_req_i      (csr_req),
    .csr_rdata_o    (csr_rdata),
    .trap_i         (trap),
    .pc_if_i        (pc_if),
    .pc_id_i        (pc_id),
    .core_id_i      (core_id),
    .cluster_id_i   (cluster_id),
    .perf_evt_i     (perf_evt),
    .mepc_o         (mepc),
    .mtvec_o        (mtvec),
    .m_irq_enable_o (m_irq_enable)
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // event bits in counter order
  function automatic logic [11:0] event_vector(csr_pkg::perf_evt_t e, logic idv_q);
    return {e.pipeline_stall,
            e.id_valid & e.is_decoding & e.is_compressed,
            e.branch & e.branch_taken & idv_q,
            e.branch & idv_q,
            e.jump & idv_q,
            e.mem_store,
            e.mem_load,
            e.imiss & ~e.pc_set,
            e.jr_stall & idv_q,
            e.ld_stall & idv_q,
            e.id_valid & e.is_decoding,
            1'b1};
  endfunction

  function automatic logic [31:0] expected_read(logic [11:0] addr);
    logic [31:0] w;
    w = '0;
    case (addr)
      csr_pkg::CSR_MSTATUS: w = {19'b0, 2'b11, 3'b0, m_mstatus.mpie, 3'b0, m_mstatus.mie, 3'b0};
      csr_pkg::CSR_MTVEC:   w = {m_mtvec, 6'b0, csr_pkg::MTVEC_MODE};
      csr_pkg::CSR_MEPC:    w = m_mepc;
      csr_pkg::CSR_MCAUSE:  w = {m_mcause[5], 26'b0, m_mcause[4:0]};
      csr_pkg::CSR_MHARTID: w = {21'b0, cluster_id, 1'b0, core_id};
      csr_pkg::CSR_PCER:    w = {20'b0, m_pcer};
      csr_pkg::CSR_PCMR:    w = {30'b0, m_pcmr};
      default: begin
        if (addr[11:5] == csr_pkg::PCCR_GROUP && addr[4:0] < 5'd12) begin
          w = m_cnt[addr[3:0]];
        end
      end
    endcase
    return w;
  endfunction

  function automatic logic [31:0] resolve_wdata(csr_pkg::csr_op_e op, logic [31:0] wd,
                                                logic [31:0] rd);
    case (op)
      csr_pkg::CSR_OP_SET:   return wd | rd;
      csr_pkg::CSR_OP_CLEAR: return rd & ~wd;
      default:               return wd;
    endcase
  endfunction

  function automatic void model_reset();
    m_mstatus = '{mie: 1'b0, mpie: 1'b0, mpp: csr_pkg::PRIV_LVL_M};
    m_mtvec   = '0;
    m_mepc    = '0;
    m_mcause  = '0;
    m_pcer    = '0;
    m_pcmr    = 2'b11;
    m_inc     = '0;
    m_idv     = 1'b0;
    foreach (m_cnt[i]) m_cnt[i] = '0;
  endfunction

  function automatic void model_step();
    logic [31:0]       wd;
    logic [11:0]       a;
    logic              we;
    csr_pkg::mstatus_t old_st;
    a      = csr_req.addr.raw;
    we     = csr_req.access && (csr_req.op != csr_pkg::CSR_OP_NONE);
    wd     = resolve_wdata(csr_req.op, csr_req.wdata, expected_read(a));
    old_st = m_mstatus;
    // increments from last cycle, then the CSR write on top
    for (int i = 0; i < 12; i++) begin
      if (m_inc[i] && (m_cnt[i] != 32'hffff_ffff || !m_pcmr[1])) begin
        m_cnt[i] = m_cnt[i] + 32'd1;
      end
      if (we && a[11:5] == csr_pkg::PCCR_GROUP &&
          (a == csr_pkg::CSR_PCCR_ALL || a[4:0] == i[4:0])) begin
        m_cnt[i] = wd;
      end
    end
    m_inc = event_vector(perf_evt, m_idv) & m_pcer & {12{m_pcmr[0]}};
    m_idv = perf_evt.id_valid;
    if (we) begin
      case (a)
        csr_pkg::CSR_PCER:    m_pcer = wd[11:0];
        csr_pkg::CSR_PCMR:    m_pcmr = wd[1:0];
        csr_pkg::CSR_MSTATUS: m_mstatus = '{mie: wd[3], mpie: wd[7], mpp: csr_pkg::PRIV_LVL_M};
        csr_pkg::CSR_MTVEC:   m_mtvec = wd[31:8];
        csr_pkg::CSR_MEPC:    m_mepc = wd;
        csr_pkg::CSR_MCAUSE:  m_mcause = {wd[31], wd[4:0]};
        default: ;
      endcase
    end
    if (trap.save_cause) begin
      m_mepc         = trap.save_if ? pc_if : pc_id;
      m_mcause       = trap.cause;
      m_mstatus.mpie = old_st.mie;
      m_mstatus.mie  = 1'b0;
    end else if (trap.restore_mret) begin
      m_mstatus.mie  = old_st.mpie;
      m_mstatus.mpie = 1'b1;
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, logic [csr_pkg::XLEN-1:0] exp,
                            logic [csr_pkg::XLEN-1:0] act);
    n_checks++;
    if (act !== exp) begin
      $display("CHECK FAILED time %0t signal %s expected %h actual %h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_mstatus(csr_pkg::mstatus_t exp, csr_pkg::mstatus_t act);
    n_checks++;
    if (act !== exp) begin
      $display("CHECK FAILED time %0t signal mstatus expected %b actual %b", $time, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    n_checks++;
    if (act !== exp) begin
      $display("CHECK FAILED time %0t signal %s expected %b actual %b", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  // outputs are stable at the falling edge, inputs settled half a cycle before
  always @(negedge clk) begin : compare
    csr_pkg::mstatus_t seen;
    if (!rst_n) begin
      model_reset();
    end else begin
      // mstatus fields first, the whole word then covers the reserved bits
      if (csr_req.access && csr_req.addr.raw == csr_pkg::CSR_MSTATUS) begin
        seen = '{mie: csr_rdata[3], mpie: csr_rdata[7],
                 mpp: csr_pkg::priv_lvl_e'(csr_rdata[12:11])};
        check_mstatus(m_mstatus, seen);
      end
      check_word("csr_rdata_o", csr_req.access ? expected_read(csr_req.addr.raw) : 32'h0,
                 csr_rdata);
      check_word("mepc_o", m_mepc, mepc);
      check_word("mtvec_o", {8'h0, m_mtvec}, {8'h0, mtvec});
      check_bit("m_irq_enable_o", m_mstatus.mie, m_irq_enable);
      model_step();
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk);
    #0.5;
    r        = next_rand();
    perf_evt = r[12:0];
    pc_if    = next_rand();
    pc_id    = next_rand();
  endtask

  task automatic csr_access(logic [11:0] addr, csr_pkg::csr_op_e op, logic [31:0] wdata);
    csr_req.access   = 1'b1;
    csr_req.addr.raw = addr;
    csr_req.op       = op;
    csr_req.wdata    = wdata;
    next_cycle();
    csr_req.access = 1'b0;
    csr_req.op     = csr_pkg::CSR_OP_NONE;
  endtask

  // trap entry, optionally with a CSR write in the same cycle
  task automatic trap_entry(logic with_write);
    logic [31:0] r;
    r = next_rand();
    trap.save_cause = 1'b1;
    trap.save_if    = r[6];
    trap.save_id    = ~r[6];
    trap.cause      = r[5:0];
    if (with_write) begin
      csr_req.access = 1'b1;
      csr_req.op     = csr_pkg::CSR_OP_WRITE;
      csr_req.wdata  = next_rand();
      case (r[9:8])
        2'd0:    csr_req.addr.raw = csr_pkg::CSR_MEPC;
        2'd1:    csr_req.addr.raw = csr_pkg::CSR_MCAUSE;
        2'd2:    csr_req.addr.raw = csr_pkg::CSR_MSTATUS;
        default: csr_req.addr.raw = csr_pkg::CSR_MTVEC;
      endcase
    end
    next_cycle();
    trap           = '0;
    csr_req.access = 1'b0;
  endtask

  task automatic mret();
    trap.restore_mret = 1'b1;
    next_cycle();
    trap = '0;
  endtask

  task automatic wait_irq_level(logic level, int max_cycles);
    int n;
    n = 0;
    while (m_irq_enable !== level) begin
      if (n == max_cycles) begin
        $display("timeout: m_irq_enable_o did not reach %b", level);
        stop_on_failure();
      end
      next_cycle();
      n++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0]      r;
    csr_pkg::csr_op_e op;
    rst_n      = 1'b0;
    csr_req    = '0;
    trap       = '0;
    pc_if      = '0;
    pc_id      = '0;
    core_id    = 4'h9;
    cluster_id = 6'h2d;
    perf_evt   = '0;
    repeat (2) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    // reset values
    foreach (addr_list[i]) csr_access(addr_list[i], csr_pkg::CSR_OP_NONE, 32'h0);

    // write, set and clear with read-back
    for (int k = 0; k < 30; k++) begin
      r  = next_rand();
      op = (r[1:0] == 2'b00) ? csr_pkg::CSR_OP_WRITE : csr_pkg::csr_op_e'(r[1:0]);
      csr_access(addr_list[r[5:4] % 2'd3], op, next_rand());
      csr_access(addr_list[r[5:4] % 2'd3], csr_pkg::CSR_OP_NONE, 32'h0);
    end
    csr_access(csr_pkg::CSR_MHARTID, csr_pkg::CSR_OP_WRITE, next_rand());
    csr_access(csr_pkg::CSR_MHARTID, csr_pkg::CSR_OP_NONE, 32'h0);

    // trap entry and MRET
    csr_access(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_OP_SET, 32'h8);
    for (int k = 0; k < 8; k++) begin
      trap_entry(k[0]);
      wait_irq_level(1'b0, 4);
      csr_access(csr_pkg::CSR_MEPC, csr_pkg::CSR_OP_NONE, 32'h0);
      csr_access(csr_pkg::CSR_MCAUSE, csr_pkg::CSR_OP_NONE, 32'h0);
      csr_access(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_OP_NONE, 32'h0);
      mret();
      wait_irq_level(1'b1, 4);
    end

    // counters with random enables and events
    csr_access(csr_pkg::CSR_PCCR_ALL, csr_pkg::CSR_OP_WRITE, 32'h0);
    csr_access(csr_pkg::CSR_PCER, csr_pkg::CSR_OP_WRITE, next_rand());
    csr_access(csr_pkg::CSR_PCMR, csr_pkg::CSR_OP_WRITE, 32'h1);
    for (int k = 0; k < 150; k++) begin
      if (k == 75) csr_access(csr_pkg::CSR_PCER, csr_pkg::CSR_OP_WRITE, next_rand());
      r = next_rand();
      csr_access(12'h780 + 12'(r % 32'd12), csr_pkg::CSR_OP_NONE, 32'h0);
    end

    // saturation hold, then wrap
    csr_access(csr_pkg::CSR_PCER, csr_pkg::CSR_OP_WRITE, 32'hfff);
    csr_access(csr_pkg::CSR_PCMR, csr_pkg::CSR_OP_WRITE, 32'h3);
    csr_access(12'h780, csr_pkg::CSR_OP_WRITE, 32'hffff_fffd);
    csr_req = '{access: 1'b1, addr: 12'h780, op: csr_pkg::CSR_OP_NONE, wdata: 32'h0};
    repeat (6) next_cycle();
    check_word("cycle counter at saturation", 32'hffff_ffff, csr_rdata);
    csr_access(csr_pkg::CSR_PCMR, csr_pkg::CSR_OP_WRITE, 32'h1);
    repeat (4) csr_access(12'h780, csr_pkg::CSR_OP_NONE, 32'h0);
    csr_access(csr_pkg::CSR_PCCR_ALL, csr_pkg::CSR_OP_WRITE, next_rand());
    for (int i = 0; i < 32; i++) csr_access(12'h780 + 12'(i), csr_pkg::CSR_OP_NONE, 32'h0);
    csr_access(12'h78d, csr_pkg::CSR_OP_WRITE, next_rand());
    csr_access(12'h78d, csr_pkg::CSR_OP_NONE, 32'h0);

    // long random mix
    repeat (600) begin
      r              = next_rand();
      csr_req.access = r[0] | r[1];
      if (!r[5]) begin
        csr_req.addr.raw = addr_list[r[4:2]];
      end else if (!r[4]) begin
        csr_req.addr.raw = {csr_pkg::PCCR_GROUP, r[10:6]};
      end else begin
        csr_req.addr.raw = r[31:20];
      end
      csr_req.op        = csr_pkg::csr_op_e'(r[12:11]);
      csr_req.wdata     = next_rand();
      trap.save_cause   = (r[17:14] == 4'h0);
      trap.restore_mret = (r[17:14] == 4'h1);
      trap.save_if      = r[18];
      trap.save_id      = ~r[18];
      trap.cause        = r[24:19];
      next_cycle();
    end
    csr_req = '0;
    trap    = '0;
    repeat (2) next_cycle();

    if (n_checks > 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("no comparisons were made");
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

// File: csr_unit.f
common/csr_pkg.sv
perf/perf_events.sv
perf/perf_counter_bank.sv
trap/trap_csr.sv
logic/csr_unit.sv
verif/csr_unit_properties.sv
verif/csr_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
